//--- Makefile
VERILATOR  ?= verilator
TOP        ?= coreTop_tb
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+.
core_pkg.sv
fetchUnit.sv
instDecoder.sv
regFile.sv
execAlu.sv
csrFile.sv
writeBack.sv
coreTop.sv
coreTop_sva.sv
coreTop_tb.sv

//--- coreTop.sv
`timescale 1ns/1ps

module coreTop (
  input  logic              clk,
  input  logic              reset,
  output logic [63:0]       instAddr,
  input  logic [31:0]       instData,
  output logic [63:0]       memAddr,
  output logic [63:0]       memWdata,
  output logic              memRead,
  output logic              memWrite,
  input  logic [63:0]       memRdata,
  output logic              regWrite,
  output logic [4:0]        regAddr,
  output logic [63:0]       regData
);

  logic [63:0] pc, imm, rs1Data, rs2Data, aluResult;
  logic [63:0] csrRdata, mtvec, mepc;
  logic [4:0]  rs1Addr, rs2Addr, rdAddr;
  logic [11:0] csrAddr;
  logic        useImm, usePc, branchNe, takeBranch;
  logic        decRegWrite, decMemRead, decMemWrite, csrWrite;
  logic        trapEcall, trapIllegal, doMret;
  logic        regWriteEn, memWriteEn;
  core_pkg::aluOpT aluOp;
  core_pkg::wbSelT wbSel;
  core_pkg::pcSelT pcSel;

  assign doMret     = (pcSel == core_pkg::PcMret);
  assign regWriteEn = decRegWrite && !reset;            // no writes during reset
  assign memWriteEn = decMemWrite && !reset;
  assign instAddr   = pc;
  assign memAddr    = aluResult;
  assign memWdata   = rs2Data;
  assign regAddr    = rdAddr;

  fetchUnit fetch (.clk(clk), .reset(reset), .pcSel(pcSel), .takeBranch(takeBranch),
    .imm(imm), .rs1Data(rs1Data), .mtvec(mtvec), .mepc(mepc), .pc(pc));

  instDecoder decoder (.inst(instData), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
    .rdAddr(rdAddr), .imm(imm), .aluOp(aluOp), .useImm(useImm), .usePc(usePc),
    .branchNe(branchNe), .regWrite(decRegWrite), .memRead(decMemRead),
    .memWrite(decMemWrite), .csrWrite(csrWrite), .trapEcall(trapEcall),
    .trapIllegal(trapIllegal), .wbSel(wbSel), .pcSel(pcSel), .csrAddr(csrAddr));

  regFile regs (.clk(clk), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdAddr),
    .writeEn(regWrite), .writeData(regData), .rs1Data(rs1Data), .rs2Data(rs2Data));

  execAlu alu (.pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .aluOp(aluOp),
    .useImm(useImm), .usePc(usePc), .branchNe(branchNe), .aluResult(aluResult),
    .takeBranch(takeBranch));

  csrFile csrs (.clk(clk), .reset(reset), .csrAddr(csrAddr), .csrWrite(csrWrite),
    .csrWdata(rs1Data), .trapEcall(trapEcall), .trapIllegal(trapIllegal),
    .doMret(doMret), .pc(pc), .csrRdata(csrRdata), .mtvec(mtvec), .mepc(mepc));

  writeBack wb (.aluResult(aluResult), .memRdata(memRdata), .pc(pc), .csrRdata(csrRdata),
    .wbSel(wbSel), .memRead(decMemRead), .memWrite(memWriteEn), .regWriteIn(regWriteEn),
    .memReadOut(memRead), .memWriteOut(memWrite), .regWriteOut(regWrite),
    .regData(regData));

endmodule

//--- coreTop_sva.sv
`timescale 1ns/1ps

module coreTopSva (
  input logic        clk,
  input logic        reset,
  input logic [63:0] instAddr,
  input logic        memRead,
  input logic        memWrite,
  input logic        regWrite,
  input logic [4:0]  regAddr
);

  memExclusive: assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite))
    else $error("memRead and memWrite are high in the same cycle");

  noZeroWrite: assert property (@(posedge clk) disable iff (reset) regWrite |-> regAddr != 5'd0)
    else $error("register write to x0 on the retire port");

  // fetch stays word aligned
  pcAligned: assert property (@(posedge clk) disable iff (reset) instAddr[1:0] == 2'b00)
    else $error("instAddr is not word aligned");

  quietAfterReset: assert property (@(posedge clk) $past(reset) && !reset |-> !memWrite && !regWrite)
    else $error("write strobe high in the first cycle after reset");

endmodule

bind coreTop coreTopSva sva (.clk(clk), .reset(reset), .instAddr(instAddr), .memRead(memRead),
  .memWrite(memWrite), .regWrite(regWrite), .regAddr(regAddr));

//--- coreTop_tb.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module coreTop_tb;

  localparam int FirstRand = 35;                  // after csr setup and register init
  localparam int EndIdx    = 335;                 // final self jump
  localparam int ProgLen   = EndIdx + 1;
  localparam int Limit     = 16 + 2 * ProgLen + 50;

  logic        clk, reset;
  logic [63:0] instAddr, memAddr, memWdata, memRdata, regData;
  logic [31:0] instData;
  logic        memRead, memWrite, regWrite;
  logic [4:0]  regAddr;

  logic [31:0] prog [1024];
  logic [63:0] dmem [256];
  bit          isTarget [1024];
  int          genPos;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [11:0] lastOff = 12'd0;

  // reference model state
  logic [63:0] mPc, mMtvec, mMepc, mMcause;
  logic [63:0] mRegs [32];
  logic [63:0] mDmem [256];
  logic        expRegWrite, expMemWrite, expMemRead;
  logic [4:0]  expRd;
  logic [63:0] expRegData, expMemAddr, expMemData;
  int          lastIdx;
  string       tag;

  // upper address bits ignored, so sign-extended lui targets alias the program
  assign instData = prog[instAddr[11:2]];
  assign memRdata = dmem[memAddr[10:3]];

  always @(posedge clk) begin
    if (memWrite) begin
      dmem[memAddr[10:3]] <= memWdata;
    end
  end

  coreTop uut (.clk(clk), .reset(reset), .instAddr(instAddr), .instData(instData),
    .memAddr(memAddr), .memWdata(memWdata), .memRead(memRead), .memWrite(memWrite),
    .memRdata(memRdata), .regWrite(regWrite), .regAddr(regAddr), .regData(regData));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > Limit) begin
      $display("timeout after %0d cycles, the program never reached its final jump", cycles);
      errors++;
      finishRun();
    end
  end

  task automatic finishRun();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic compareValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s expected %h actual %h", name, expected, actual);
    end
  endtask

  function automatic logic [63:0] fillWord(int k);
    return {32'(k) ^ 32'h5a5a_5a5a, ~32'(k)};
  endfunction

  function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, core_pkg::Op};
  endfunction

  function automatic logic [31:0] encB(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_pkg::Branch};
  endfunction

  function automatic logic [31:0] encJ(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, core_pkg::Jal};
  endfunction

  // random forward target clamped to the final jump
  function automatic int forwardTarget(int from, int maxStep);
    int t;
    t = from + int'($urandom_range(1, maxStep));
    if (t > EndIdx) t = EndIdx;
    isTarget[10'(t)] = 1'b1;
    return t;
  endfunction

  task automatic put(input logic [31:0] w);
    prog[10'(genPos)] = w;
    genPos++;
  endtask

  task automatic buildProgram();
    int kind, tgt;
    logic [4:0] rd, rs1, rs2;
    logic coin;
    for (int k = 0; k < 1024; k++) begin
      prog[10'(k)] = 32'h0;
      isTarget[10'(k)] = 1'b0;
    end
    prog[0] = encI(12'd0, 5'd0, 3'b000, 5'd0, core_pkg::OpImm);     // nop
    prog[1] = encJ(21'd8, 5'd1);                                     // x1 <- handler
    prog[2] = 32'h30200073;                                          // handler: mret
    prog[3] = encI(core_pkg::CsrMtvec, 5'd1, 3'b001, 5'd5, core_pkg::System);
    prog[4] = encI(core_pkg::CsrMtvec, 5'd1, 3'b001, 5'd6, core_pkg::System);
    for (int r = 2; r < 32; r++) begin
      prog[10'(r + 3)] = encI(12'($urandom), 5'd0, 3'b000, 5'(r), core_pkg::OpImm);
    end
    genPos = FirstRand;
    while (genPos < EndIdx) begin
      kind = int'($urandom_range(0, 15));
      rd   = 5'($urandom_range(0, 31));
      rs1  = 5'($urandom_range(0, 31));
      rs2  = 5'($urandom_range(0, 31));
      coin = 1'($urandom_range(0, 1));
      case (kind)
        1: put(encR(7'h00, rs2, rs1, 3'b000, rd));
        2: put(encR(7'h20, rs2, rs1, 3'b000, rd));
        3: put(encR(7'h00, rs2, rs1, 3'b111, rd));
        4: put(encR(7'h00, rs2, rs1, 3'b110, rd));
        5: put(encR(7'h00, rs2, rs1, 3'b100, rd));
        6: put(encR(7'h00, rs2, rs1, 3'b010, rd));
        7: put({20'($urandom), rd, core_pkg::Lui});
        8: begin
          if (coin) lastOff = 12'(8 * $urandom_range(0, 255));     // else reread last sd
          put(encI(lastOff, 5'd0, 3'b011, rd, core_pkg::Load));
        end
        9: begin
          lastOff = 12'(8 * $urandom_range(0, 255));
          put({lastOff[11:5], rs2, 5'd0, 3'b011, lastOff[4:0], core_pkg::Store});
        end
        10: begin
          if (coin) rs2 = rs1;                                       // taken beq more often
          tgt = forwardTarget(genPos, 6);
          put(encB(13'((tgt - genPos) * 4), rs2, rs1, {2'b00, 1'($urandom_range(0, 1))}));
        end
        11: begin
          tgt = forwardTarget(genPos, 6);
          put(encJ(21'((tgt - genPos) * 4), rd));
        end
        12: begin
          if (genPos + 3 <= EndIdx && !isTarget[10'(genPos + 1)]
              && !isTarget[10'(genPos + 2)]) begin
            rs1 = 5'($urandom_range(1, 31));
            tgt = forwardTarget(genPos + 2, 4);
            put({20'h80000, rs1, core_pkg::Lui});
            put(encI(12'(tgt * 4), rs1, 3'b000, rs1, core_pkg::OpImm));
            put(encI(12'd0, rs1, 3'b000, rd, core_pkg::Jalr));
          end else begin
            put(encI(12'($urandom), rs1, 3'b000, rd, core_pkg::OpImm));
          end
        end
        13, 14: begin
          if (kind == 13) begin
            put(32'h00000073);
          end else begin
            case ($urandom_range(0, 3))
              0: put(32'h00000000);
              1: put(32'h00109093);                                  // slli
              2: put(32'h00002073);                                  // csrrs
              default: put(32'hffffffff);
            endcase
          end
          if (genPos + 2 <= EndIdx) begin
            put(encI(core_pkg::CsrMepc, 5'd0, 3'b001, rd, core_pkg::System));
            put(encI(core_pkg::CsrMcause, 5'd0, 3'b001, rs2, core_pkg::System));
          end
        end
        15: put(encI(coin ? core_pkg::CsrMepc : core_pkg::CsrMcause, rs1, 3'b001, rd,
                     core_pkg::System));
        default: put(encI(12'($urandom), rs1, 3'b000, rd, core_pkg::OpImm));
      endcase
    end
    prog[10'(EndIdx)] = encJ(21'd0, 5'd0);
  endtask

  function automatic logic [63:0] csrRead(logic [11:0] addr);
    case (addr)
      core_pkg::CsrMstatus: return `CORE_MSTATUS_RESET;
      core_pkg::CsrMtvec:   return mMtvec;
      core_pkg::CsrMepc:    return mMepc;
      core_pkg::CsrMcause:  return mMcause;
      default:              return 64'd0;
    endcase
  endfunction

  // executes one instruction on the model state and records what should retire
  task automatic modelStep();
    logic [31:0] w;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [63:0] a, b, iI, iS, iB, iJ, res, nextPc, addr;
    logic        doWrite, trap, ecall;
    lastIdx = int'(mPc[11:2]);
    w   = prog[mPc[11:2]];
    op  = w[6:0];
    f3  = w[14:12];
    rd  = w[11:7];
    a   = mRegs[w[19:15]];
    b   = mRegs[w[24:20]];
    iI  = {{52{w[31]}}, w[31:20]};
    iS  = {{52{w[31]}}, w[31:25], w[11:7]};
    iB  = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    iJ  = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    res = 64'd0;
    doWrite = 1'b0;
    trap    = 1'b0;
    ecall   = 1'b0;
    nextPc  = mPc + 64'd4;
    expMemWrite = 1'b0;
    expMemRead  = 1'b0;
    expMemAddr  = 64'd0;
    expMemData  = 64'd0;
    tag = "alu";
    case (op)
      core_pkg::OpImm: begin
        res = a + iI;
        doWrite = (f3 == 3'b000);
        trap = !doWrite;
      end
      core_pkg::Op: begin
        doWrite = 1'b1;
        case ({w[31:25], f3})
          {7'h00, 3'b000}: res = a + b;
          {7'h20, 3'b000}: res = a - b;
          {7'h00, 3'b111}: res = a & b;
          {7'h00, 3'b110}: res = a | b;
          {7'h00, 3'b100}: res = a ^ b;
          {7'h00, 3'b010}: res = {63'd0, $signed(a) < $signed(b)};
          default: trap = 1'b1;
        endcase
      end
      core_pkg::Lui: begin
        tag = "lui";
        res = {{32{w[31]}}, w[31:12], 12'd0};
        doWrite = 1'b1;
      end
      core_pkg::Load: begin
        tag = "ld";
        addr = a + iI;
        res = mDmem[addr[10:3]];
        doWrite = (f3 == 3'b011);
        trap = !doWrite;
        expMemRead = doWrite;
        expMemAddr = addr;
      end
      core_pkg::Store: begin
        tag = "sd";
        if (f3 == 3'b011) begin
          expMemWrite = 1'b1;
          expMemAddr  = a + iS;
          expMemData  = b;
          mDmem[expMemAddr[10:3]] = b;
        end else begin
          trap = 1'b1;
        end
      end
      core_pkg::Branch: begin
        tag = "branch";
        if (f3[2:1] != 2'b00) trap = 1'b1;
        else if ((a == b) ^ f3[0]) nextPc = mPc + iB;
      end
      core_pkg::Jal: begin
        tag = "jal";
        res = mPc + 64'd4;
        doWrite = 1'b1;
        nextPc = mPc + iJ;
      end
      core_pkg::Jalr: begin
        tag = "jalr";
        res = mPc + 64'd4;
        doWrite = (f3 == 3'b000);
        trap = !doWrite;
        nextPc = (a + iI) & ~64'd1;
      end
      core_pkg::System: begin
        if (f3 == 3'b001) begin
          tag = "csrrw";
          res = csrRead(w[31:20]);                                   // old value retires
          doWrite = 1'b1;
          case (w[31:20])
            core_pkg::CsrMtvec:  mMtvec  = a;
            core_pkg::CsrMepc:   mMepc   = a;
            core_pkg::CsrMcause: mMcause = a;
            default: ;
          endcase
        end else if (w == 32'h00000073) begin
          trap  = 1'b1;
          ecall = 1'b1;
        end else if (w == 32'h30200073) begin
          tag = "mret";
          nextPc = mMepc;
        end else begin
          trap = 1'b1;
        end
      end
      default: trap = 1'b1;
    endcase
    if (trap) begin
      tag     = ecall ? "ecall" : "illegal";
      doWrite = 1'b0;
      mMepc   = mPc + 64'd4;
      mMcause = ecall ? `CORE_CAUSE_ECALL : `CORE_CAUSE_ILLEGAL;
      nextPc  = mMtvec;
    end
    expRegWrite = doWrite && (rd != 5'd0);
    expRd       = rd;
    expRegData  = res;
    if (expRegWrite) mRegs[rd] = res;
    mPc = nextPc;
  endtask

  initial begin
    void'($urandom(88));
    reset = 1'b1;
    for (int k = 0; k < 256; k++) begin
      dmem[8'(k)]  = fillWord(k);
      mDmem[8'(k)] = fillWord(k);
    end
    for (int r = 0; r < 32; r++) mRegs[5'(r)] = 64'd0;
    buildProgram();
    mPc     = `CORE_RESET_PC;
    mMtvec  = 64'd0;
    mMepc   = 64'd0;
    mMcause = 64'd0;
    lastIdx = 0;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);
    compareValue("reset instAddr", `CORE_RESET_PC, instAddr);
    compareValue("reset memWrite", 64'd0, 64'(memWrite));
    compareValue("reset regWrite", 64'd0, 64'(regWrite));
    while (lastIdx != EndIdx) begin
      compareValue("instAddr", mPc, instAddr);
      modelStep();
      compareValue({tag, " regWrite"}, 64'(expRegWrite), 64'(regWrite));
      if (expRegWrite) begin
        compareValue({tag, " regAddr"}, 64'(expRd), 64'(regAddr));
        compareValue({tag, " regData"}, expRegData, regData);
      end
      compareValue({tag, " memRead"}, 64'(expMemRead), 64'(memRead));
      compareValue({tag, " memWrite"}, 64'(expMemWrite), 64'(memWrite));
      if (expMemRead || expMemWrite) begin
        compareValue({tag, " memAddr"}, expMemAddr, memAddr);
      end
      if (expMemWrite) begin
        compareValue({tag, " memWdata"}, expMemData, memWdata);
      end
      @(negedge clk);
    end
    finishRun();
  end

endmodule

//--- core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch address
`define CORE_RESET_PC 64'h80000000

// mcause codes
`define CORE_CAUSE_ECALL   64'd11
`define CORE_CAUSE_ILLEGAL 64'd2

`define CORE_MSTATUS_RESET 64'h0

`endif

//--- core_pkg.sv
package core_pkg;

  // rv64 major opcodes of the supported subset
  typedef enum logic [6:0] {
    OpImm  = 7'b0010011,
    Op     = 7'b0110011,
    Lui    = 7'b0110111,
    Load   = 7'b0000011,
    Store  = 7'b0100011,
    Branch = 7'b1100011,
    Jal    = 7'b1101111,
    Jalr   = 7'b1100111,
    System = 7'b1110011
  } opcodeT;

  typedef enum logic [2:0] {
    AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluPassB
  } aluOpT;

  typedef enum logic [1:0] {
    WbAlu, WbMem, WbPc4, WbCsr
  } wbSelT;

  typedef enum logic [2:0] {
    PcSeq, PcBranch, PcJal, PcJalr, PcTrap, PcMret
  } pcSelT;

  typedef enum logic [11:0] {
    CsrMstatus = 12'h300,
    CsrMtvec   = 12'h305,
    CsrMepc    = 12'h341,
    CsrMcause  = 12'h342
  } csrAddrT;

endpackage

//--- csrFile.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module csrFile (
  input  logic              clk,
  input  logic              reset,
  input  logic [11:0]       csrAddr,
  input  logic              csrWrite,
  input  logic [63:0]       csrWdata,
  input  logic              trapEcall,
  input  logic              trapIllegal,
  input  logic              doMret,
  input  logic [63:0]       pc,
  output logic [63:0]       csrRdata,
  output logic [63:0]       mtvec,
  output logic [63:0]       mepc
);

  logic [63:0] mstatus;
  logic [63:0] mcause;
  core_pkg::csrAddrT addr;

  assign addr = core_pkg::csrAddrT'(csrAddr);

  always_comb begin
    case (addr)
      core_pkg::CsrMstatus: csrRdata = mstatus;
      core_pkg::CsrMtvec:   csrRdata = mtvec;
      core_pkg::CsrMepc:    csrRdata = mepc;
      core_pkg::CsrMcause:  csrRdata = mcause;
      default:              csrRdata = 64'd0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mstatus <= `CORE_MSTATUS_RESET;
      mtvec   <= 64'd0;
      mepc    <= 64'd0;
      mcause  <= 64'd0;
    end else if (trapEcall || trapIllegal) begin
      // trap wins over a software write
      mepc       <= pc + 64'd4;
      mcause     <= trapEcall ? `CORE_CAUSE_ECALL : `CORE_CAUSE_ILLEGAL;
      mstatus[7] <= mstatus[3];                         // mpie <= mie
      mstatus[3] <= 1'b0;
    end else if (doMret) begin
      mstatus[3] <= mstatus[7];
      mstatus[7] <= 1'b1;
    end else if (csrWrite) begin
      case (addr)
        core_pkg::CsrMstatus: mstatus <= csrWdata;
        core_pkg::CsrMtvec:   mtvec   <= csrWdata;
        core_pkg::CsrMepc:    mepc    <= csrWdata;
        core_pkg::CsrMcause:  mcause  <= csrWdata;
        default: ;                                      // unknown csr ignored
      endcase
    end
  end

endmodule

//--- execAlu.sv
`timescale 1ns/1ps

module execAlu (
  input  logic [63:0]       pc,
  input  logic [63:0]       rs1Data,
  input  logic [63:0]       rs2Data,
  input  logic [63:0]       imm,
  input  core_pkg::aluOpT   aluOp,
  input  logic              useImm,
  input  logic              usePc,
  input  logic              branchNe,
  output logic [63:0]       aluResult,
  output logic              takeBranch
);

  logic [63:0] opA;
  logic [63:0] opB;

  assign opA = usePc ? pc : rs1Data;
  assign opB = useImm ? imm : rs2Data;

  always_comb begin
    case (aluOp)
      core_pkg::AluSub:   aluResult = opA - opB;
      core_pkg::AluAnd:   aluResult = opA & opB;
      core_pkg::AluOr:    aluResult = opA | opB;
      core_pkg::AluXor:   aluResult = opA ^ opB;
      core_pkg::AluSlt:   aluResult = {63'd0, $signed(opA) < $signed(opB)};
      core_pkg::AluPassB: aluResult = opB;              // lui
      default:            aluResult = opA + opB;
    endcase
  end

  assign takeBranch = (rs1Data == rs2Data) ^ branchNe;  // beq, or bne when inverted

endmodule

//--- fetchUnit.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetchUnit (
  input  logic              clk,
  input  logic              reset,
  input  core_pkg::pcSelT   pcSel,
  input  logic              takeBranch,
  input  logic [63:0]       imm,
  input  logic [63:0]       rs1Data,
  input  logic [63:0]       mtvec,
  input  logic [63:0]       mepc,
  output logic [63:0]       pc
);

  logic [63:0] seqPc;
  logic [63:0] relPc;
  logic [63:0] jalrPc;
  logic [63:0] nextPc;

  assign seqPc  = pc + 64'd4;
  assign relPc  = pc + imm;                       // branch and jal target
  assign jalrPc = (rs1Data + imm) & ~64'd1;

  always_comb begin
    case (pcSel)
      core_pkg::PcBranch: nextPc = takeBranch ? relPc : seqPc;
      core_pkg::PcJal:    nextPc = relPc;
      core_pkg::PcJalr:   nextPc = jalrPc;
      core_pkg::PcTrap:   nextPc = mtvec;
      core_pkg::PcMret:   nextPc = mepc;
      default:            nextPc = seqPc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `CORE_RESET_PC;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

//--- instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
  input  logic [31:0]       inst,
  output logic [4:0]        rs1Addr,
  output logic [4:0]        rs2Addr,
  output logic [4:0]        rdAddr,
  output logic [63:0]       imm,
  output core_pkg::aluOpT   aluOp,
  output logic              useImm,
  output logic              usePc,
  output logic              branchNe,
  output logic              regWrite,
  output logic              memRead,
  output logic              memWrite,
  output logic              csrWrite,
  output logic              trapEcall,
  output logic              trapIllegal,
  output core_pkg::wbSelT   wbSel,
  output core_pkg::pcSelT   pcSel,
  output logic [11:0]       csrAddr
);

  core_pkg::opcodeT opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [63:0] immI, immS, immB, immU, immJ;
  logic        wantWrite;

  assign opcode  = core_pkg::opcodeT'(inst[6:0]);
  assign funct3  = inst[14:12];
  assign funct7  = inst[31:25];
  assign rs1Addr = inst[19:15];
  assign rs2Addr = inst[24:20];
  assign rdAddr  = inst[11:7];
  assign csrAddr = inst[31:20];

  assign immI = {{52{inst[31]}}, inst[31:20]};
  assign immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign immJ = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // never retire a write to x0
  assign regWrite = wantWrite && (rdAddr != 5'd0);

  always_comb begin
    aluOp       = core_pkg::AluAdd;
    imm         = 64'd0;
    useImm      = 1'b0;
    usePc       = 1'b0;
    branchNe    = 1'b0;
    wantWrite   = 1'b0;
    memRead     = 1'b0;
    memWrite    = 1'b0;
    csrWrite    = 1'b0;
    trapEcall   = 1'b0;
    trapIllegal = 1'b0;
    wbSel       = core_pkg::WbAlu;
    pcSel       = core_pkg::PcSeq;
    case (opcode)
      core_pkg::OpImm: begin
        imm    = immI;
        useImm = 1'b1;
        if (funct3 == 3'b000) wantWrite = 1'b1;       // addi only
        else trapIllegal = 1'b1;
      end
      core_pkg::Op: begin
        wantWrite = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: aluOp = core_pkg::AluAdd;
          10'b0100000_000: aluOp = core_pkg::AluSub;
          10'b0000000_111: aluOp = core_pkg::AluAnd;
          10'b0000000_110: aluOp = core_pkg::AluOr;
          10'b0000000_100: aluOp = core_pkg::AluXor;
          10'b0000000_010: aluOp = core_pkg::AluSlt;
          default: trapIllegal = 1'b1;
        endcase
      end
      core_pkg::Lui: begin
        aluOp     = core_pkg::AluPassB;
        imm       = immU;
        useImm    = 1'b1;
        wantWrite = 1'b1;
      end
      core_pkg::Load: begin
        imm    = immI;
        useImm = 1'b1;
        wbSel  = core_pkg::WbMem;
        if (funct3 == 3'b011) begin                    // ld
          memRead   = 1'b1;
          wantWrite = 1'b1;
        end else begin
          trapIllegal = 1'b1;
        end
      end
      core_pkg::Store: begin
        imm    = immS;
        useImm = 1'b1;
        if (funct3 == 3'b011) memWrite = 1'b1;          // sd
        else trapIllegal = 1'b1;
      end
      core_pkg::Branch: begin
        imm    = immB;
        useImm = 1'b1;
        usePc  = 1'b1;                                  // alu shows the target
        pcSel  = core_pkg::PcBranch;
        case (funct3)
          3'b000:  branchNe = 1'b0;
          3'b001:  branchNe = 1'b1;
          default: trapIllegal = 1'b1;
        endcase
      end
      core_pkg::Jal: begin
        imm       = immJ;
        useImm    = 1'b1;
        usePc     = 1'b1;
        wantWrite = 1'b1;
        wbSel     = core_pkg::WbPc4;
        pcSel     = core_pkg::PcJal;
      end
      core_pkg::Jalr: begin
        imm    = immI;
        useImm = 1'b1;
        wbSel  = core_pkg::WbPc4;
        pcSel  = core_pkg::PcJalr;
        if (funct3 == 3'b000) wantWrite = 1'b1;
        else trapIllegal = 1'b1;
      end
      core_pkg::System: begin
        if (funct3 == 3'b001) begin                    // csrrw
          csrWrite  = 1'b1;
          wantWrite = 1'b1;
          wbSel     = core_pkg::WbCsr;
        end else if (inst == 32'h00000073) begin
          trapEcall = 1'b1;
          pcSel     = core_pkg::PcTrap;
        end else if (inst == 32'h30200073) begin
          pcSel = core_pkg::PcMret;
        end else begin
          trapIllegal = 1'b1;
        end
      end
      default: trapIllegal = 1'b1;
    endcase

    // unknown word: trap with all strobes low
    if (trapIllegal) begin
      wantWrite = 1'b0;
      memRead   = 1'b0;
      memWrite  = 1'b0;
      csrWrite  = 1'b0;
      pcSel     = core_pkg::PcTrap;
    end
  end

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic              clk,
  input  logic [4:0]        rs1Addr,
  input  logic [4:0]        rs2Addr,
  input  logic [4:0]        rdAddr,
  input  logic              writeEn,
  input  logic [63:0]       writeData,
  output logic [63:0]       rs1Data,
  output logic [63:0]       rs2Data
);

  logic [63:0] regs [31:0];

  always_ff @(posedge clk) begin
    if (writeEn && rdAddr != 5'd0) begin
      regs[rdAddr] <= writeData;
    end
  end

  // x0 reads as zero
  assign rs1Data = (rs1Addr == 5'd0) ? 64'd0 : regs[rs1Addr];
  assign rs2Data = (rs2Addr == 5'd0) ? 64'd0 : regs[rs2Addr];

endmodule

//--- writeBack.sv
`timescale 1ns/1ps

module writeBack (
  input  logic [63:0]       aluResult,
  input  logic [63:0]       memRdata,
  input  logic [63:0]       pc,
  input  logic [63:0]       csrRdata,
  input  core_pkg::wbSelT   wbSel,
  input  logic              memRead,
  input  logic              memWrite,
  input  logic              regWriteIn,
  output logic              memReadOut,
  output logic              memWriteOut,
  output logic              regWriteOut,
  output logic [63:0]       regData
);

  logic [63:0] pcPlus4;

  assign pcPlus4 = pc + 64'd4;                          // link value

  // strobes go straight to memory and register file
  assign memReadOut  = memRead;
  assign memWriteOut = memWrite;
  assign regWriteOut = regWriteIn;

  always_comb begin
    case (wbSel)
      core_pkg::WbMem: regData = memRdata;
      core_pkg::WbPc4: regData = pcPlus4;
      core_pkg::WbCsr: regData = csrRdata;              // old csr value
      default:         regData = aluResult;
    endcase
  end

endmodule
